//--- video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

////////////////////////////////////////////////////////////
// Raster widths
////////////////////////////////////////////////////////////

// Counter and timing limit width, covers SXGA line total
`define VID_CNT_W 11

// Cycles from counter value to hsync/vsync/vde at the pins
`define VID_OUT_DELAY 2

// Switch code synchronizer depth
`define SW_SYNC_STAGES 2

////////////////////////////////////////////////////////////
// Aux data islands
////////////////////////////////////////////////////////////

`define AUX_WORD_W 12     // One aux word per island cycle
`define AUX_NIBBLE_W 4    // One lane per TMDS channel
`define AUX_ISLAND_LEN 32 // Island length in cycles

`endif

//--- video_timing_pkg.sv
`include "video_defines.svh"

package video_timing_pkg;

	////////////////////////////////////////////////////////////
	// Mode selection
	////////////////////////////////////////////////////////////

	// Switch codes, anything else falls back to 720p
	typedef enum logic [3:0] {
		MODE_VGA    = 4'b0000, // 640x480
		MODE_SVGA   = 4'b0001, // 800x600
		MODE_720P   = 4'b0010, // 1280x720
		MODE_XGA    = 4'b0011, // 1024x768
		MODE_SXGA   = 4'b1000, // 1280x1024
		MODE_CAMERA = 4'b1001  // 720p variant, shorter sync
	} mode_code_t;

	////////////////////////////////////////////////////////////
	// Raster position and limits
	////////////////////////////////////////////////////////////

	// Pixel or line position
	typedef logic [`VID_CNT_W-1:0] vid_cnt_t;

	// Sync polarity
	// 1 means active low sync
	typedef logic sync_pol_t;

	localparam sync_pol_t SYNC_POS = 1'b0;
	localparam sync_pol_t SYNC_NEG = 1'b1;

	// Last count of each region
	// sblnk = active - 1
	// ssync = sblnk + front porch
	// esync = ssync + sync width
	// eblnk = esync + back porch, last count of the line/frame
	typedef struct packed {
		vid_cnt_t hsblnk; // Last active pixel
		vid_cnt_t hssync; // Last pixel before hsync
		vid_cnt_t hesync; // Last hsync pixel
		vid_cnt_t heblnk; // Line wraps here
		vid_cnt_t vsblnk; // Last active line
		vid_cnt_t vssync; // Last line before vsync
		vid_cnt_t vesync; // Last vsync line
		vid_cnt_t veblnk; // Frame wraps here
	} timing_limits_t;

endpackage

//--- aux_island_pkg.sv
`include "video_defines.svh"

package aux_island_pkg;

	// Lanes in one aux word
	localparam int AUX_LANES = `AUX_WORD_W / `AUX_NIBBLE_W;

	// One lane, carried on one TMDS channel
	typedef logic [`AUX_NIBBLE_W-1:0] aux_nibble_t;

	// Aux word, lane 0 in the low nibble
	typedef aux_nibble_t [AUX_LANES-1:0] aux_word_t;

	// Cycle index inside an island
	typedef logic [$clog2(`AUX_ISLAND_LEN)-1:0] island_cnt_t;

	// Final island cycle
	localparam island_cnt_t ISLAND_LAST = island_cnt_t'(`AUX_ISLAND_LEN - 1);

endpackage

//--- video_mode_ctrl.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module video_mode_ctrl (
	input  logic                             clk50m_bufg,
	input  logic                             reset,
	input  logic [3:0]                       mode_sel, // Raw switch code
	output video_timing_pkg::timing_limits_t limits,
	output video_timing_pkg::sync_pol_t      polarity,
	output logic                             restart   // One cycle on mode change
);

	localparam int SYNC_N = `SW_SYNC_STAGES;

	////////////////////////////////////////////////////////////
	// Limit calculation
	////////////////////////////////////////////////////////////

	// Region ends from active size, porches and pulse widths
	function automatic video_timing_pkg::timing_limits_t calc_limits(
		input int hpix, hfp, hpw, hbp,
		input int vlin, vfp, vpw, vbp
	);
		video_timing_pkg::timing_limits_t lim;
		lim.hsblnk = video_timing_pkg::vid_cnt_t'(hpix - 1);
		lim.hssync = video_timing_pkg::vid_cnt_t'(hpix - 1 + hfp);
		lim.hesync = video_timing_pkg::vid_cnt_t'(hpix - 1 + hfp + hpw);
		lim.heblnk = video_timing_pkg::vid_cnt_t'(hpix - 1 + hfp + hpw + hbp);
		lim.vsblnk = video_timing_pkg::vid_cnt_t'(vlin - 1);
		lim.vssync = video_timing_pkg::vid_cnt_t'(vlin - 1 + vfp);
		lim.vesync = video_timing_pkg::vid_cnt_t'(vlin - 1 + vfp + vpw);
		lim.veblnk = video_timing_pkg::vid_cnt_t'(vlin - 1 + vfp + vpw + vbp);
		return lim;
	endfunction

	// Args: h pixels, h front, h sync, h back, v lines, v front, v sync, v back
	localparam video_timing_pkg::timing_limits_t LIM_VGA =
		calc_limits(640, 16, 96, 48, 480, 11, 2, 31);
	localparam video_timing_pkg::timing_limits_t LIM_SVGA =
		calc_limits(800, 40, 128, 88, 600, 1, 4, 23);
	localparam video_timing_pkg::timing_limits_t LIM_XGA =
		calc_limits(1024, 24, 136, 160, 768, 3, 6, 29);
	localparam video_timing_pkg::timing_limits_t LIM_720P =
		calc_limits(1280, 110, 40, 220, 720, 5, 5, 20);
	localparam video_timing_pkg::timing_limits_t LIM_SXGA =
		calc_limits(1280, 48, 112, 248, 1024, 1, 3, 38);
	localparam video_timing_pkg::timing_limits_t LIM_CAMERA =
		calc_limits(1280, 110, 39, 220, 720, 4, 4, 22); // 720p with 39 wide hsync

	////////////////////////////////////////////////////////////
	// Switch synchronizer and change detect
	////////////////////////////////////////////////////////////

	logic [3:0] sw_sync [SYNC_N]; // Synchronizer chain
	logic [3:0] mode_q;           // Settled mode code

	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			// Start on 720p so the first settle does not restart
			for (int i = 0; i < SYNC_N; i++) begin
				sw_sync[i] <= video_timing_pkg::MODE_720P;
			end
			mode_q  <= video_timing_pkg::MODE_720P;
			restart <= 1'b0;
		end else begin
			sw_sync[0] <= mode_sel;
			for (int i = 1; i < SYNC_N; i++) begin
				sw_sync[i] <= sw_sync[i-1];
			end
			mode_q  <= sw_sync[SYNC_N-1];
			restart <= (sw_sync[SYNC_N-1] != mode_q); // Lands with the new mode
		end
	end

	// Mode decode
	always_comb begin
		limits   = LIM_720P;
		polarity = video_timing_pkg::SYNC_POS;
		case (mode_q)
			video_timing_pkg::MODE_VGA: begin
				limits   = LIM_VGA;
				polarity = video_timing_pkg::SYNC_NEG;
			end
			video_timing_pkg::MODE_SVGA:   limits = LIM_SVGA;
			video_timing_pkg::MODE_XGA: begin
				limits   = LIM_XGA;
				polarity = video_timing_pkg::SYNC_NEG;
			end
			video_timing_pkg::MODE_SXGA:   limits = LIM_SXGA;
			video_timing_pkg::MODE_CAMERA: limits = LIM_CAMERA;
			default:                       limits = LIM_720P; // 720p and unlisted codes
		endcase
	end

endmodule

//--- raster_generator.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module raster_generator (
	input  logic                             clk50m_bufg,
	input  logic                             reset,
	input  logic                             restart,  // Back to 0,0
	input  video_timing_pkg::timing_limits_t limits,
	input  video_timing_pkg::sync_pol_t      polarity,
	output video_timing_pkg::vid_cnt_t       hcount,   // Live counter, to scheduler
	output logic                             active,   // Live, neither blank set
	output logic                             hsync,
	output logic                             vsync,
	output logic                             vde,
	output video_timing_pkg::vid_cnt_t       hcount_out, // Aligned with vde
	output video_timing_pkg::vid_cnt_t       vcount_out
);

	localparam int OUT_DLY = `VID_OUT_DELAY;

	video_timing_pkg::vid_cnt_t vcount;
	logic line_end;   // Last pixel of the line
	logic frame_end;  // Last line of the frame
	logic hblnk;
	logic vblnk;
	logic hsync_int;  // Before polarity
	logic vsync_int;

	////////////////////////////////////////////////////////////
	// Horizontal and vertical counters
	////////////////////////////////////////////////////////////

	// >= covers a counter left past a shorter line
	assign line_end  = (hcount >= limits.heblnk);
	assign frame_end = (vcount >= limits.veblnk);

	always_ff @(posedge clk50m_bufg) begin
		if (reset || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end)
				vcount <= '0; // Frame wrap
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Blank past the last active count
	assign hblnk  = (hcount > limits.hsblnk);
	assign vblnk  = (vcount > limits.vsblnk);
	assign active = !hblnk && !vblnk;

	// Sync after ssync, up to and including esync
	assign hsync_int = (hcount > limits.hssync) && (hcount <= limits.hesync);
	assign vsync_int = (vcount > limits.vssync) && (vcount <= limits.vesync);

	////////////////////////////////////////////////////////////
	// Output pipeline
	////////////////////////////////////////////////////////////

	logic [OUT_DLY-1:0] hsync_pipe;
	logic [OUT_DLY-1:0] vsync_pipe;
	logic [OUT_DLY-1:0] vde_pipe;
	video_timing_pkg::vid_cnt_t hpos_pipe [OUT_DLY];
	video_timing_pkg::vid_cnt_t vpos_pipe [OUT_DLY];

	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			hsync_pipe <= '0; // Inactive for the 720p default
			vsync_pipe <= '0;
			vde_pipe   <= '0;
		end else begin
			hsync_pipe <= {hsync_pipe[OUT_DLY-2:0], hsync_int ^ polarity};
			vsync_pipe <= {vsync_pipe[OUT_DLY-2:0], vsync_int ^ polarity};
			vde_pipe   <= {vde_pipe[OUT_DLY-2:0], active};
		end
	end

	// Position follows the same stages
	always_ff @(posedge clk50m_bufg) begin
		hpos_pipe[0] <= hcount;
		vpos_pipe[0] <= vcount;
		for (int i = 1; i < OUT_DLY; i++) begin
			hpos_pipe[i] <= hpos_pipe[i-1];
			vpos_pipe[i] <= vpos_pipe[i-1];
		end
	end

	assign hsync      = hsync_pipe[OUT_DLY-1];
	assign vsync      = vsync_pipe[OUT_DLY-1];
	assign vde        = vde_pipe[OUT_DLY-1];
	assign hcount_out = hpos_pipe[OUT_DLY-1];
	assign vcount_out = vpos_pipe[OUT_DLY-1];

endmodule

//--- aux_island_scheduler.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module aux_island_scheduler (
	input  logic                       clk50m_bufg,
	input  logic                       reset,
	input  logic                       restart,
	input  video_timing_pkg::vid_cnt_t hcount,    // Live counter
	input  logic                       active,    // Live active video
	input  logic                       aux_valid,
	input  aux_island_pkg::aux_word_t  aux_word,
	output logic                       aux_ready,
	output logic                       ade,       // Island enable, raster aligned
	output aux_island_pkg::aux_word_t  aux_data
);

	logic                        pos_held;    // Next island position is known
	aux_island_pkg::aux_word_t   pos_q;       // Position word as received
	logic                        island_open; // First stage of the island flag
	aux_island_pkg::island_cnt_t island_cnt;
	logic                        take_word;   // Handshake on this edge
	logic                        pos_match;
	logic                        open_hit;

	////////////////////////////////////////////////////////////
	// Aux stream intake
	////////////////////////////////////////////////////////////

	// Ready while waiting for a position or inside an island
	// Does not look at aux_valid
	assign aux_ready = !pos_held || island_open;
	assign take_word = aux_valid && aux_ready;

	// Position word, top bit set never matches
	always_ff @(posedge clk50m_bufg) begin
		if (take_word && !island_open)
			pos_q <= aux_word;
	end

	////////////////////////////////////////////////////////////
	// Island window
	////////////////////////////////////////////////////////////

	assign pos_match = (pos_q == {1'b0, hcount});
	assign open_hit  = pos_held && !island_open && !active && pos_match; // Blanking only

	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			pos_held    <= 1'b0;
			island_open <= 1'b0;
			island_cnt  <= '0;
		end else if (island_open) begin
			// A running island always finishes its 32 cycles
			if (island_cnt == aux_island_pkg::ISLAND_LAST) begin
				island_open <= 1'b0;
				island_cnt  <= '0;
				pos_held    <= 1'b0; // Next word is a position again
			end else begin
				island_cnt <= island_cnt + 1'b1;
			end
		end else begin
			if (take_word)
				pos_held <= 1'b1; // Only taken while no position is held
			else if (restart)
				pos_held <= 1'b0; // Stale position after mode change

			if (open_hit && !restart)
				island_open <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Second stage, lines up with hsync/vde
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (reset)
			ade <= 1'b0;
		else
			ade <= island_open;
	end

	// Word accepted in an island cycle, zero on underrun
	always_ff @(posedge clk50m_bufg) begin
		if (island_open && aux_valid)
			aux_data <= aux_word;
		else
			aux_data <= '0;
	end

endmodule

//--- video_aux_top.sv
`timescale 1ns/1ps

module video_aux_top (
	input  logic                                             clk50m_bufg,
	input  logic                                             reset,
	input  logic [$bits(video_timing_pkg::mode_code_t)-1:0] mode_sel,
	input  logic                                             aux_valid,
	input  aux_island_pkg::aux_word_t                        aux_word,
	output logic                                             aux_ready,
	output logic                                             hsync,
	output logic                                             vsync,
	output logic                                             vde,
	output video_timing_pkg::vid_cnt_t                       hcount_out,
	output video_timing_pkg::vid_cnt_t                       vcount_out,
	output logic                                             ade,
	output aux_island_pkg::aux_word_t                        aux_data
);

	video_timing_pkg::timing_limits_t limits;   // Current mode limits
	video_timing_pkg::sync_pol_t      polarity;
	logic                             restart;  // Mode change pulse
	video_timing_pkg::vid_cnt_t       hcount;   // Live raster position
	logic                             active;

	// Switch code to timing limits
	video_mode_ctrl i_video_mode_ctrl (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.mode_sel    (mode_sel),
		.limits      (limits),
		.polarity    (polarity),
		.restart     (restart)
	);

	// Counters, blank/sync decode, output pipeline
	raster_generator i_raster_generator (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.restart     (restart),
		.limits      (limits),
		.polarity    (polarity),
		.hcount      (hcount),
		.active      (active),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde),
		.hcount_out  (hcount_out),
		.vcount_out  (vcount_out)
	);

	// Aux islands in blanking
	aux_island_scheduler i_aux_island_scheduler (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.restart     (restart),
		.hcount      (hcount),
		.active      (active),
		.aux_valid   (aux_valid),
		.aux_word    (aux_word),
		.aux_ready   (aux_ready),
		.ade         (ade),
		.aux_data    (aux_data)
	);

endmodule

//--- video_aux_checker.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module video_aux_checker (
	input logic clk50m_bufg,
	input logic reset,
	input logic ade,
	input logic vde
);

	int ade_len;          // Cycles of the current ade pulse
	int assert_fails = 0; // Failed assertion count

	always_ff @(posedge clk50m_bufg) begin
		if (reset || !ade)
			ade_len <= 0;
		else
			ade_len <= ade_len + 1;
	end

	////////////////////////////////////////////////////////////
	// Island properties
	////////////////////////////////////////////////////////////

	// Islands only in blanking
	a_no_overlap: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!(ade && vde))
		else begin
			$error("ade and vde high in the same cycle");
			assert_fails++;
		end

	a_island_max: assert property (@(posedge clk50m_bufg) disable iff (reset)
		ade |-> ade_len < `AUX_ISLAND_LEN)
		else begin
			$error("ade pulse longer than one island");
			assert_fails++;
		end

	a_island_len: assert property (@(posedge clk50m_bufg) disable iff (reset)
		$fell(ade) |-> ade_len == `AUX_ISLAND_LEN)
		else begin
			$error("ade pulse ended early, %0d cycles", ade_len);
			assert_fails++;
		end

	// Quiet right after reset
	a_reset_quiet: assert property (@(posedge clk50m_bufg)
		($past(reset) || $past(reset, 2)) |-> !ade)
		else begin
			$error("ade high right after reset");
			assert_fails++;
		end

endmodule

//--- tb_video_aux_top.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module tb_video_aux_top;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 4;
	localparam int N_ROWS       = 7;
	localparam int SETTLE_LINES = 4;
	localparam int VGA_VSW      = 2;    // VGA vsync lines
	localparam int POS_A        = 1300; // Both islands sit in 720p hblank
	localparam int POS_B        = 1400;
	localparam int RESTART_CYC  = `SW_SYNC_STAGES + 2 + `VID_OUT_DELAY; // Sync, compare, clear, pipe

	typedef struct packed {
		video_timing_pkg::mode_code_t code;
		int   htotal; // Cycles per line
		int   hsw;    // hsync width
		int   hact;   // Active pixels
		logic pol;    // 1 for active low
		int   vtotal; // Lines per frame
	} mode_row_t;

	// Totals from the porch and pulse values of each mode
	localparam mode_row_t MODE_TAB [N_ROWS] = '{
		'{video_timing_pkg::MODE_VGA,    800,  96,  640,  1'b1, 524},
		'{video_timing_pkg::MODE_SVGA,   1056, 128, 800,  1'b0, 628},
		'{video_timing_pkg::MODE_XGA,    1344, 136, 1024, 1'b1, 806},
		'{video_timing_pkg::MODE_720P,   1650, 40,  1280, 1'b0, 750},
		'{video_timing_pkg::MODE_SXGA,   1688, 112, 1280, 1'b0, 1066},
		'{video_timing_pkg::MODE_CAMERA, 1649, 39,  1280, 1'b0, 750},
		'{video_timing_pkg::mode_code_t'(4'b0101), 1650, 40, 1280, 1'b0, 750} // Falls back to 720p
	};

	logic clk50m_bufg;
	logic reset;
	video_timing_pkg::mode_code_t mode_sel;
	logic aux_valid;
	logic [`AUX_WORD_W-1:0] aux_word;
	logic aux_ready;
	logic hsync;
	logic vsync;
	logic vde;
	video_timing_pkg::vid_cnt_t hcount_out;
	video_timing_pkg::vid_cnt_t vcount_out;
	logic ade;
	logic [`AUX_WORD_W-1:0] aux_data;

	logic [`AUX_WORD_W-1:0] aux_tab [66]; // Position A, 32 words, position B, 32 words
	int send_idx;                         // Next word offered
	int send_cnt;                         // Words loaded
	int unsigned lcg_state;

	video_aux_top i_video_aux_top (.*);

	bind video_aux_top video_aux_checker i_video_aux_checker (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.ade         (ade),
		.vde         (vde)
	);

	always #(CLK_PERIOD / 2) clk50m_bufg = ~clk50m_bufg;

	// Aux source, a word stays on the bus until the handshake
	always @(posedge clk50m_bufg) begin : aux_source
		if (aux_valid && aux_ready)
			send_idx = send_idx + 1;
		aux_valid <= (send_idx < send_cnt);
		aux_word  <= (send_idx < send_cnt) ? aux_tab[send_idx] : '0;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Run length in cycles, per phase of the test
	function automatic int watchdog_cycles();
		int total;
		total = RESET_CYCLES + 1000;
		for (int i = 0; i < N_ROWS; i++)
			total += 10 * MODE_TAB[i].htotal;                 // Settle, pulse, one line
		total += 40 * MODE_TAB[3].htotal;                     // Islands, wait for mid-frame
		total += 3 * MODE_TAB[0].htotal * MODE_TAB[0].vtotal; // VGA vsync
		return total;
	endfunction

	function automatic logic sync_level(input bit use_vsync);
		return use_vsync ? vsync : hsync;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Width and period of a sync pulse, ends on a fresh active edge
	task automatic measure_pulse(input bit use_vsync, input logic act_lvl,
		output int width, output int period);
		int n;
		@(negedge clk50m_bufg);
		while (sync_level(use_vsync) == act_lvl) @(negedge clk50m_bufg);
		while (sync_level(use_vsync) != act_lvl) @(negedge clk50m_bufg);
		n = 0;
		while (sync_level(use_vsync) == act_lvl) begin
			n++;
			@(negedge clk50m_bufg);
		end
		width = n;
		while (sync_level(use_vsync) != act_lvl) begin
			n++;
			@(negedge clk50m_bufg);
		end
		period = n;
	endtask

	task automatic check_active_line(input int htotal, input int hact);
		int n_vde;
		n_vde = 0;
		repeat (htotal) begin
			if (vde) begin
				check_value("hcount_out", n_vde, int'(hcount_out)); // Runs from zero
				n_vde++;
			end
			@(negedge clk50m_bufg);
		end
		check_value("vde cycles", hact, n_vde);
	endtask

	task automatic check_island(input int pos, input int first);
		while (ade !== 1'b1) @(negedge clk50m_bufg);
		check_value("hcount_out at ade", pos, int'(hcount_out));
		for (int i = 0; i < `AUX_ISLAND_LEN; i++) begin
			check_value("ade", 1, int'(ade));
			check_value("aux_data", int'(aux_tab[first + i]), int'(aux_data));
			@(negedge clk50m_bufg);
		end
		check_value("ade after island", 0, int'(ade));
	endtask

	// Stop on the first failed assertion
	always @(negedge clk50m_bufg)
		check_value("assertion failures", 0, i_video_aux_top.i_video_aux_checker.assert_fails);

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		int width;
		int period;
		int n;
		mode_row_t row;
		clk50m_bufg = 1'b0;
		reset       = 1'b1;
		mode_sel    = video_timing_pkg::MODE_720P; // Same as the reset mode
		aux_valid   = 1'b0;
		aux_word    = '0;
		send_idx    = 0;
		send_cnt    = 0;
		lcg_state   = 32'd69311;
		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		reset <= 1'b0;

		for (int i = 0; i < N_ROWS; i++) begin
			row = MODE_TAB[i];
			@(posedge clk50m_bufg);
			mode_sel <= row.code;
			repeat (SETTLE_LINES * row.htotal) @(negedge clk50m_bufg);
			measure_pulse(1'b0, !row.pol, width, period);
			check_value("hsync period", row.htotal, period);
			check_value("hsync width", row.hsw, width);
			check_active_line(row.htotal, row.hact);
		end

		// Two islands, still on the 720p fallback
		aux_tab[0]  = POS_A;
		aux_tab[33] = POS_B;
		for (int i = 0; i < 2 * `AUX_ISLAND_LEN; i++) begin
			lcg_state = lcg_next(lcg_state);
			aux_tab[(i < `AUX_ISLAND_LEN) ? 1 + i : 2 + i] = lcg_state[27:16];
		end
		@(negedge clk50m_bufg);
		check_value("aux_ready idle", 1, int'(aux_ready)); // No position held yet
		send_cnt = 66;
		while (send_idx == 0) @(negedge clk50m_bufg);
		check_value("aux_ready holding", 0, int'(aux_ready)); // Position A held
		check_island(POS_A, 1);
		check_value("aux_ready holding", 0, int'(aux_ready)); // Position B taken at once
		check_island(POS_B, 34);
		check_value("aux_ready idle", 1, int'(aux_ready)); // Stream drained

		// Switch to VGA inside active video
		while (vde !== 1'b1 || vcount_out == 0) @(negedge clk50m_bufg);
		@(posedge clk50m_bufg);
		mode_sel <= MODE_TAB[0].code;
		n = 0;
		while (n < 4 * RESTART_CYC && !(vcount_out == 0 && hcount_out == 0)) begin
			@(posedge clk50m_bufg);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("cycles to raster restart", RESTART_CYC, n);

		repeat (SETTLE_LINES * MODE_TAB[0].htotal) @(negedge clk50m_bufg);
		measure_pulse(1'b1, !MODE_TAB[0].pol, width, period);
		check_value("vsync period", MODE_TAB[0].vtotal * MODE_TAB[0].htotal, period);
		check_value("vsync width", VGA_VSW * MODE_TAB[0].htotal, width);

		if (i_video_aux_top.i_video_aux_checker.assert_fails == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Assertions failed during the run");
			$display("Regression failed");
			$fatal(1, "assertion failures");
		end
	end

	initial begin : watchdog
		repeat (watchdog_cycles()) @(posedge clk50m_bufg);
		$display("Timeout, the test sequence did not finish in %0d cycles", watchdog_cycles());
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- all.f
+incdir+.
video_timing_pkg.sv
aux_island_pkg.sv
video_mode_ctrl.sv
raster_generator.sv
aux_island_scheduler.sv
video_aux_top.sv
video_aux_checker.sv
tb_video_aux_top.sv
